// ==== common/ooo_params.svh ====
`ifndef OOO_PARAMS_SVH
`define OOO_PARAMS_SVH

// Data and instruction word width
`define WORD_W 16

// log2 of the reorder buffer entry count
`define ROB_DEPTH 3

// Number of ALU reservation stations
`define RS_COUNT 3

`endif

// ==== common/lc3b_isa_pkg.sv ====
`include "ooo_params.svh"

package lc3b_isa_pkg;

	typedef logic [`WORD_W-1:0] lc3b_word;
	typedef logic [2:0] lc3b_reg;

	// Full LC-3b opcode map
	// Only ADD, AND and NOT are executed
	typedef enum logic [3:0]
	{
		op_br   = 4'b0000,
		op_add  = 4'b0001,
		op_ldb  = 4'b0010,
		op_stb  = 4'b0011,
		op_jsr  = 4'b0100,
		op_and  = 4'b0101,
		op_ldr  = 4'b0110,
		op_str  = 4'b0111,
		op_rti  = 4'b1000,
		op_not  = 4'b1001,
		op_ldi  = 4'b1010,
		op_sti  = 4'b1011,
		op_jmp  = 4'b1100,
		op_shf  = 4'b1101,
		op_lea  = 4'b1110,
		op_trap = 4'b1111
	} lc3b_opcode;

endpackage

// ==== common/ooo_pkg.sv ====
`include "ooo_params.svh"

package ooo_pkg;

	// Names the ROB entry that produces a value
	typedef logic [`ROB_DEPTH-1:0] rob_tag;

	typedef enum logic [1:0]
	{
		entry_empty   = 2'b00,
		entry_waiting = 2'b01,
		entry_done    = 2'b10
	} rob_state;

endpackage

// ==== source/fetch_unit.sv ====
`timescale 1ns/100ps

module fetch_unit
	import lc3b_isa_pkg::*;
(
	input  logic     clk,
	input  logic     rst_n,
	input  lc3b_word imem_rdata,
	input  logic     imem_resp,
	input  logic     stall,
	output logic     imem_read,
	output lc3b_word imem_address,
	output lc3b_word instr,
	output logic     instr_valid
);

	typedef enum logic {fetch_reading, fetch_holding} fetch_state;

	fetch_state state;
	lc3b_word   pc;

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state <= fetch_reading;
			pc <= '0;
		end
		else
		begin
			case (state)
				fetch_reading:
				begin
					if (imem_resp)
					begin
						state <= fetch_holding;
						pc <= pc + lc3b_word'(2);
					end
				end
				// Word stays latched until issue takes it
				fetch_holding:
				begin
					if (!stall)
						state <= fetch_reading;
				end
				default: state <= fetch_reading;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (state == fetch_reading && imem_resp)
			instr <= imem_rdata;
	end

	assign imem_read    = (state == fetch_reading);
	assign imem_address = pc;
	assign instr_valid  = (state == fetch_holding);

endmodule

// ==== issue/regfile.sv ====
`timescale 1ns/100ps

module regfile
	import lc3b_isa_pkg::*;
	import ooo_pkg::*;
(
	input  logic     clk,
	input  logic     rst_n,
	input  lc3b_reg  sr1,
	input  lc3b_reg  sr2,
	input  lc3b_reg  dest,
	input  logic     set_busy,
	input  rob_tag   busy_tag,
	input  logic     commit_valid,
	input  lc3b_reg  commit_reg,
	input  rob_tag   commit_tag,
	input  lc3b_word commit_value,
	output lc3b_word sr1_value,
	output logic     sr1_busy,
	output rob_tag   sr1_tag,
	output lc3b_word sr2_value,
	output logic     sr2_busy,
	output rob_tag   sr2_tag
);

	lc3b_word regs [8];
	logic     busy [8];
	rob_tag   tags [8];

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			for (int i = 0; i < 8; i++)
			begin
				regs[i] <= '0;
				busy[i] <= 1'b0;
			end
		end
		else
		begin
			// Retire is in order, so the value is always the newest architectural one
			if (commit_valid)
			begin
				regs[commit_reg] <= commit_value;
				if (tags[commit_reg] == commit_tag)
					busy[commit_reg] <= 1'b0;
			end
			// New rename overrides a clear to the same register
			if (set_busy)
				busy[dest] <= 1'b1;
		end
	end

	always_ff @(posedge clk)
	begin
		if (set_busy)
			tags[dest] <= busy_tag;
	end

	assign sr1_value = regs[sr1];
	assign sr1_busy  = busy[sr1];
	assign sr1_tag   = tags[sr1];
	assign sr2_value = regs[sr2];
	assign sr2_busy  = busy[sr2];
	assign sr2_tag   = tags[sr2];

endmodule

// ==== issue/issue_control.sv ====
`timescale 1ns/100ps
`include "ooo_params.svh"

module issue_control
	import lc3b_isa_pkg::*;
	import ooo_pkg::*;
(
	input  logic       clk,
	input  logic       rst_n,
	input  lc3b_word   instr,
	input  logic       instr_valid,
	input  logic       rob_full,
	input  logic       rs_full,
	input  rob_tag     rob_tail,
	input  lc3b_word   sr1_value,
	input  logic       sr1_busy,
	input  rob_tag     sr1_tag,
	input  lc3b_word   sr2_value,
	input  logic       sr2_busy,
	input  rob_tag     sr2_tag,
	input  logic       src1_ready,
	input  lc3b_word   src1_value,
	input  logic       src2_ready,
	input  lc3b_word   src2_value,
	input  logic       cdb_valid,
	input  rob_tag     cdb_tag,
	input  lc3b_word   cdb_value,
	output logic       stall,
	output lc3b_reg    sr1,
	output lc3b_reg    sr2,
	output lc3b_reg    dest,
	output logic       set_busy,
	output rob_tag     src1_tag,
	output rob_tag     src2_tag,
	output logic       rob_write,
	output lc3b_reg    rob_dest_reg,
	output logic       rs_load,
	output lc3b_opcode rs_op,
	output lc3b_word   rs_vj,
	output lc3b_word   rs_vk,
	output rob_tag     rs_qj,
	output rob_tag     rs_qk,
	output logic       rs_j_ready,
	output logic       rs_k_ready,
	output rob_tag     rs_tag
);

	// Returns {ready, value}; regfile first, then a done ROB entry, then the CDB
	function automatic logic [`WORD_W:0] resolve
	(
		input logic     busy,
		input lc3b_word reg_value,
		input rob_tag   tag,
		input logic     rob_ready,
		input lc3b_word rob_value,
		input logic     bus_valid,
		input rob_tag   bus_tag,
		input lc3b_word bus_value
	);
		if (!busy)
			return {1'b1, reg_value};
		else if (rob_ready)
			return {1'b1, rob_value};
		else if (bus_valid && bus_tag == tag)
			return {1'b1, bus_value};
		else
			return {1'b0, reg_value};
	endfunction

	lc3b_opcode       opcode;
	logic             accept;
	logic             imm_sel;
	lc3b_word         imm5_ext;
	logic [`WORD_W:0] src1_res;
	logic [`WORD_W:0] src2_res;

	assign opcode   = lc3b_opcode'(instr[15:12]);
	assign imm_sel  = instr[5];
	assign imm5_ext = {{(`WORD_W-5){instr[4]}}, instr[4:0]};

	assign stall  = rob_full | rs_full;
	assign accept = instr_valid & ~stall;

	assign dest     = instr[11:9];
	assign sr1      = instr[8:6];
	assign sr2      = instr[2:0];
	assign src1_tag = sr1_tag;
	assign src2_tag = sr2_tag;

	assign src1_res = resolve(sr1_busy, sr1_value, sr1_tag, src1_ready, src1_value,
		cdb_valid, cdb_tag, cdb_value);
	assign src2_res = resolve(sr2_busy, sr2_value, sr2_tag, src2_ready, src2_value,
		cdb_valid, cdb_tag, cdb_value);

	// Dispatch happens on the accepting edge
	assign set_busy     = accept;
	assign rob_write    = accept;
	assign rob_dest_reg = dest;
	assign rs_load      = accept;
	assign rs_op        = opcode;
	assign rs_tag       = rob_tail;

	assign rs_vj      = src1_res[`WORD_W-1:0];
	assign rs_j_ready = src1_res[`WORD_W];
	assign rs_qj      = sr1_tag;

	// NOT encodes all ones in imm5, so it always takes this path
	assign rs_vk      = imm_sel ? imm5_ext : src2_res[`WORD_W-1:0];
	assign rs_k_ready = imm_sel | src2_res[`WORD_W];
	assign rs_qk      = sr2_tag;

	supported_opcode: assert property (@(posedge clk) disable iff (!rst_n)
		accept |-> (opcode inside {op_add, op_and, op_not}))
		else $error("issue accepted unsupported opcode %0h", instr[15:12]);

endmodule

// ==== rob/reorder_buffer.sv ====
`timescale 1ns/100ps
`include "ooo_params.svh"

module reorder_buffer
	import lc3b_isa_pkg::*;
	import ooo_pkg::*;
(
	input  logic     clk,
	input  logic     rst_n,
	input  logic     rob_write,
	input  lc3b_reg  rob_dest_reg,
	input  logic     cdb_valid,
	input  rob_tag   cdb_tag,
	input  lc3b_word cdb_value,
	input  rob_tag   src1_tag,
	input  rob_tag   src2_tag,
	output rob_tag   rob_tail,
	output logic     rob_full,
	output logic     src1_ready,
	output lc3b_word src1_value,
	output logic     src2_ready,
	output lc3b_word src2_value,
	output logic     commit_valid,
	output lc3b_reg  commit_reg,
	output rob_tag   commit_tag,
	output lc3b_word commit_value
);

	localparam logic [`ROB_DEPTH:0] ENTRIES = 1 << `ROB_DEPTH;

	rob_state            state [ENTRIES];
	lc3b_reg             dest_q [ENTRIES];
	lc3b_word            value_q [ENTRIES];
	rob_tag              head;
	rob_tag              tail;
	logic [`ROB_DEPTH:0] count;
	logic                retire;

	assign retire = (state[head] == entry_done);

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			for (int i = 0; i < ENTRIES; i++)
				state[i] <= entry_empty;
			head <= '0;
			tail <= '0;
			count <= '0;
		end
		else
		begin
			// Head, CDB target and tail never name the same entry in one cycle
			if (retire)
			begin
				state[head] <= entry_empty;
				head <= head + 1'b1;
			end
			if (cdb_valid)
				state[cdb_tag] <= entry_done;
			if (rob_write)
			begin
				state[tail] <= entry_waiting;
				tail <= tail + 1'b1;
			end
			case ({rob_write, retire})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (rob_write)
			dest_q[tail] <= rob_dest_reg;
		if (cdb_valid)
			value_q[cdb_tag] <= cdb_value;
	end

	assign rob_tail = tail;
	assign rob_full = (count == ENTRIES);

	// Operand lookup for renamed sources
	assign src1_ready = (state[src1_tag] == entry_done);
	assign src1_value = value_q[src1_tag];
	assign src2_ready = (state[src2_tag] == entry_done);
	assign src2_value = value_q[src2_tag];

	assign commit_valid = retire;
	assign commit_reg   = dest_q[head];
	assign commit_tag   = head;
	assign commit_value = value_q[head];

	no_write_when_full: assert property (@(posedge clk) disable iff (!rst_n)
		rob_write |-> !rob_full)
		else $error("ROB written while full");

	cdb_to_waiting_entry: assert property (@(posedge clk) disable iff (!rst_n)
		cdb_valid |-> (state[cdb_tag] == entry_waiting))
		else $error("CDB result for ROB entry %0d that is not waiting", cdb_tag);

endmodule

// ==== source/alu_stations.sv ====
`timescale 1ns/100ps
`include "ooo_params.svh"

module alu_stations
	import lc3b_isa_pkg::*;
	import ooo_pkg::*;
(
	input  logic       clk,
	input  logic       rst_n,
	input  logic       rs_load,
	input  lc3b_opcode rs_op,
	input  lc3b_word   rs_vj,
	input  lc3b_word   rs_vk,
	input  rob_tag     rs_qj,
	input  rob_tag     rs_qk,
	input  logic       rs_j_ready,
	input  logic       rs_k_ready,
	input  rob_tag     rs_tag,
	output logic       rs_full,
	output logic       cdb_valid,
	output rob_tag     cdb_tag,
	output lc3b_word   cdb_value
);

	localparam int N = `RS_COUNT;

	function automatic lc3b_word alu(input lc3b_opcode opcode, input lc3b_word a,
		input lc3b_word b);
		case (opcode)
			op_add: return a + b;
			op_and: return a & b;
			op_not: return ~a;
			default: return a + b;
		endcase
	endfunction

	logic       busy [N];
	lc3b_opcode op [N];
	lc3b_word   vj [N];
	lc3b_word   vk [N];
	rob_tag     qj [N];
	rob_tag     qk [N];
	logic       j_rdy [N];
	logic       k_rdy [N];
	rob_tag     tag [N];

	logic free_found;
	int   free_idx;
	logic win_found;
	int   win_idx;

	// Lowest free slot takes the load, lowest ready slot wins the CDB
	always_comb
	begin
		free_found = 1'b0;
		free_idx = 0;
		win_found = 1'b0;
		win_idx = 0;
		for (int i = 0; i < N; i++)
		begin
			if (!busy[i] && !free_found)
			begin
				free_found = 1'b1;
				free_idx = i;
			end
			if (busy[i] && j_rdy[i] && k_rdy[i] && !win_found)
			begin
				win_found = 1'b1;
				win_idx = i;
			end
		end
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			for (int i = 0; i < N; i++)
				busy[i] <= 1'b0;
		end
		else
		begin
			if (win_found)
				busy[win_idx] <= 1'b0;
			if (rs_load && free_found)
				busy[free_idx] <= 1'b1;
		end
	end

	always_ff @(posedge clk)
	begin
		for (int i = 0; i < N; i++)
		begin
			if (rs_load && free_found && i == free_idx)
			begin
				op[i] <= rs_op;
				vj[i] <= rs_vj;
				vk[i] <= rs_vk;
				qj[i] <= rs_qj;
				qk[i] <= rs_qk;
				j_rdy[i] <= rs_j_ready;
				k_rdy[i] <= rs_k_ready;
				tag[i] <= rs_tag;
			end
			else
			begin
				// Snoop the CDB for missing operands
				if (!j_rdy[i] && cdb_valid && qj[i] == cdb_tag)
				begin
					vj[i] <= cdb_value;
					j_rdy[i] <= 1'b1;
				end
				if (!k_rdy[i] && cdb_valid && qk[i] == cdb_tag)
				begin
					vk[i] <= cdb_value;
					k_rdy[i] <= 1'b1;
				end
			end
		end
	end

	assign rs_full   = ~free_found;
	assign cdb_valid = win_found;
	assign cdb_tag   = tag[win_idx];
	assign cdb_value = alu(op[win_idx], vj[win_idx], vk[win_idx]);

	no_load_when_full: assert property (@(posedge clk) disable iff (!rst_n)
		rs_load |-> !rs_full)
		else $error("station load with all stations busy");

endmodule

// ==== source/cpu_datapath.sv ====
`timescale 1ns/100ps

module cpu_datapath
	import lc3b_isa_pkg::*;
	import ooo_pkg::*;
(
	input  logic     clk,
	input  logic     rst_n,
	input  lc3b_word imem_rdata,
	input  logic     imem_resp,
	output logic     imem_read,
	output lc3b_word imem_address,
	output logic     commit_valid,
	output lc3b_reg  commit_reg,
	output lc3b_word commit_value
);

	// Fetch and issue handshake
	lc3b_word instr;
	logic     instr_valid;
	logic     stall;

	// Rename state
	lc3b_reg  sr1, sr2, dest;
	logic     set_busy;
	lc3b_word sr1_value, sr2_value;
	logic     sr1_busy, sr2_busy;
	rob_tag   sr1_tag, sr2_tag;

	// ROB side
	logic     rob_write, rob_full;
	lc3b_reg  rob_dest_reg;
	rob_tag   rob_tail, src1_tag, src2_tag, commit_tag;
	logic     src1_ready, src2_ready;
	lc3b_word src1_value, src2_value;

	// Stations and CDB
	logic       rs_load, rs_full, rs_j_ready, rs_k_ready;
	lc3b_opcode rs_op;
	lc3b_word   rs_vj, rs_vk;
	rob_tag     rs_qj, rs_qk, rs_tag;
	logic       cdb_valid;
	rob_tag     cdb_tag;
	lc3b_word   cdb_value;

	fetch_unit u_fetch
	(
		.clk, .rst_n,
		.imem_rdata, .imem_resp, .stall,
		.imem_read, .imem_address, .instr, .instr_valid
	);

	issue_control u_issue
	(
		.clk, .rst_n,
		.instr, .instr_valid, .rob_full, .rs_full, .rob_tail,
		.sr1_value, .sr1_busy, .sr1_tag, .sr2_value, .sr2_busy, .sr2_tag,
		.src1_ready, .src1_value, .src2_ready, .src2_value,
		.cdb_valid, .cdb_tag, .cdb_value,
		.stall, .sr1, .sr2, .dest, .set_busy, .src1_tag, .src2_tag,
		.rob_write, .rob_dest_reg,
		.rs_load, .rs_op, .rs_vj, .rs_vk, .rs_qj, .rs_qk,
		.rs_j_ready, .rs_k_ready, .rs_tag
	);

	regfile u_regfile
	(
		.clk, .rst_n,
		.sr1, .sr2, .dest, .set_busy,
		.busy_tag(rob_tail),
		.commit_valid, .commit_reg, .commit_tag, .commit_value,
		.sr1_value, .sr1_busy, .sr1_tag, .sr2_value, .sr2_busy, .sr2_tag
	);

	reorder_buffer u_rob
	(
		.clk, .rst_n,
		.rob_write, .rob_dest_reg,
		.cdb_valid, .cdb_tag, .cdb_value,
		.src1_tag, .src2_tag,
		.rob_tail, .rob_full,
		.src1_ready, .src1_value, .src2_ready, .src2_value,
		.commit_valid, .commit_reg, .commit_tag, .commit_value
	);

	alu_stations u_stations
	(
		.clk, .rst_n,
		.rs_load, .rs_op, .rs_vj, .rs_vk, .rs_qj, .rs_qk,
		.rs_j_ready, .rs_k_ready, .rs_tag,
		.rs_full, .cdb_valid, .cdb_tag, .cdb_value
	);

endmodule

// ==== tb/cpu_datapath_tb.sv ====
`timescale 1ns/100ps

module cpu_datapath_tb
	import lc3b_isa_pkg::*;
();

	localparam int MAX_WORDS = 64;
	localparam int CLK_PERIOD = 8;
	localparam int CYCLES_PER_WORD = 40;

	logic     clk;
	logic     rst_n;
	lc3b_word imem_rdata;
	logic     imem_resp;
	logic     imem_read;
	lc3b_word imem_address;
	logic     commit_valid;
	lc3b_reg  commit_reg;
	lc3b_word commit_value;

	// Word 0 is the length, then program words, then register and value pairs
	logic [15:0] file_words [0:MAX_WORDS-1];
	int          prog_len;
	int          commit_count;
	int          error_count;
	integer      seed;

	cpu_datapath u_dut
	(
		.clk          (clk),
		.rst_n        (rst_n),
		.imem_rdata   (imem_rdata),
		.imem_resp    (imem_resp),
		.imem_read    (imem_read),
		.imem_address (imem_address),
		.commit_valid (commit_valid),
		.commit_reg   (commit_reg),
		.commit_value (commit_value)
	);

	initial
	begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// Instruction memory with a random response delay of 1 to 4 cycles
	task automatic serve_imem();
		lc3b_word addr;
		int       delay;
		forever
		begin
			@(posedge clk);
			#1;
			if (imem_read && int'(imem_address) / 2 < prog_len)
			begin
				addr = imem_address;
				delay = 1 + ($unsigned($random(seed)) % 4);
				repeat (delay - 1)
				begin
					@(posedge clk);
					#1;
				end
				imem_rdata = file_words[1 + int'(addr) / 2];
				imem_resp = 1'b1;
				@(posedge clk);
				#1;
				imem_resp = 1'b0;
			end
		end
	endtask

	task automatic check_commit(input lc3b_reg reg_got, input lc3b_word value_got);
		int       base;
		lc3b_reg  reg_exp;
		lc3b_word value_exp;
		base = 1 + prog_len + 2 * commit_count;
		if (commit_count >= prog_len)
		begin
			$display("Unexpected extra commit to R%0d with value 0x%04h", reg_got, value_got);
			error_count++;
		end
		else
		begin
			reg_exp = file_words[base][2:0];
			value_exp = file_words[base + 1];
			if (reg_got !== reg_exp)
			begin
				$display("[ERROR] commit %0d register: expected R%0d, actual R%0d",
					commit_count, reg_exp, reg_got);
				error_count++;
			end
			if (value_got !== value_exp)
			begin
				$display("[ERROR] commit %0d value of R%0d: expected 0x%04h, actual 0x%04h",
					commit_count, reg_exp, value_exp, value_got);
				error_count++;
			end
		end
		commit_count++;
	endtask

	// Every retirement against the next expected pair
	always @(negedge clk)
	begin
		if (rst_n && commit_valid)
			check_commit(commit_reg, commit_value);
	end

	initial
	begin
		rst_n = 1'b0;
		imem_resp = 1'b0;
		imem_rdata = '0;
		seed = 32'h3531_c15d;
		commit_count = 0;
		error_count = 0;
		$readmemh("tb/program_input.mem", file_words);
		prog_len = int'(file_words[0]);
		if ($isunknown(file_words[0]) || prog_len == 0 || 1 + 3 * prog_len > MAX_WORDS)
		begin
			$display("Program file tb/program_input.mem has no usable length word");
			$display("Testbench failed");
			$finish;
		end
		else
		begin
			repeat (4) @(posedge clk);
			#1;
			rst_n = 1'b1;
			fork
				serve_imem();
			join_none
			wait (commit_count >= prog_len);
			// A few more cycles to catch stray commits
			repeat (20) @(posedge clk);
			$display("Commits %0d of %0d, errors %0d", commit_count, prog_len, error_count);
			if (error_count == 0 && commit_count == prog_len)
				$display("Testbench passed");
			else
				$display("Testbench failed");
			$finish;
		end
	end

	// Watchdog scaled by program length
	initial
	begin
		#1;
		#(prog_len * CYCLES_PER_WORD * CLK_PERIOD);
		$display("Run timed out with only %0d of %0d expected commits seen",
			commit_count, prog_len);
		error_count++;
		$display("Commits %0d of %0d, errors %0d", commit_count, prog_len, error_count);
		$display("Testbench failed");
		$finish;
	end

endmodule

// ==== tb/program_input.mem ====
// Word 0: program length N, then N instruction words in address order
// Then N commit pairs in program order: destination register, value
0011
1225 // ADD R1, R0, #5
16ff // ADD R3, R3, #-1
54ec // AND R2, R3, #12
1842 // ADD R4, R1, R2
5ac1 // AND R5, R3, R1
9c7f // NOT R6, R1
1241 // ADD R1, R1, R1 (dependent chain start)
1244 // ADD R1, R1, R4
127d // ADD R1, R1, #-3
1241 // ADD R1, R1, R1
1242 // ADD R1, R1, R2
5f84 // AND R7, R6, R4 (independent)
917f // NOT R0, R5
1562 // ADD R2, R5, #2 (first write of R2)
1882 // ADD R4, R2, R2
55b0 // AND R2, R6, #-16 (second write of R2)
1a84 // ADD R5, R2, R4
// Expected commits
1 0005  3 ffff  2 000c  4 0011
5 0005  6 fffa  1 000a  1 001b
1 0018  1 0030  1 003c  7 0010
0 fffa  2 0007  4 000e  2 fff0
5 fffe

// ==== sources.f ====
+incdir+common
common/lc3b_isa_pkg.sv
common/ooo_pkg.sv
source/fetch_unit.sv
issue/regfile.sv
issue/issue_control.sv
rob/reorder_buffer.sv
source/alu_stations.sv
source/cpu_datapath.sv
tb/cpu_datapath_tb.sv

// ==== Bender.yml ====
package:
  name: cpu_datapath

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/lc3b_isa_pkg.sv
      - common/ooo_pkg.sv
      - source/fetch_unit.sv
      - issue/regfile.sv
      - issue/issue_control.sv
      - rob/reorder_buffer.sv
      - source/alu_stations.sv
      - source/cpu_datapath.sv
  - target: test
    files:
      - tb/cpu_datapath_tb.sv
